// ==== verilog/nkmm_pkg.sv ====
`default_nettype none

package nkmm_pkg;

    localparam int INSN_WIDTH   = 31;
    localparam int REGSEL_WIDTH = 3;
    localparam int OPSEL_WIDTH  = 3;
    localparam int IMM_WIDTH    = 16;

    // Instruction field positions with the immediate in the low bits
    localparam int MEM_WRITE_BIT = 30;
    localparam int MEM_READ_BIT  = 29;
    localparam int D_SEL_LSB     = 26;
    localparam int OP_SEL_LSB    = 23;
    localparam int A_SEL_LSB     = 20;
    localparam int B_SEL_LSB     = 17;
    localparam int IMM_EN_BIT    = 16;

    // ALU operations
    localparam logic [OPSEL_WIDTH-1:0] OP_ADD = 3'd0;
    localparam logic [OPSEL_WIDTH-1:0] OP_SUB = 3'd1;
    localparam logic [OPSEL_WIDTH-1:0] OP_OR  = 3'd2;
    localparam logic [OPSEL_WIDTH-1:0] OP_AND = 3'd3;
    localparam logic [OPSEL_WIDTH-1:0] OP_XOR = 3'd4;
    localparam logic [OPSEL_WIDTH-1:0] OP_NOT = 3'd5;
    localparam logic [OPSEL_WIDTH-1:0] OP_SHI = 3'd6;

    // Shift amount in the two low bits of B
    localparam logic [1:0] SHI_1 = 2'd0;
    localparam logic [1:0] SHI_2 = 2'd1;
    localparam logic [1:0] SHI_4 = 2'd2;
    localparam logic [1:0] SHI_8 = 2'd3;
    localparam int SHI_LEFT_BIT  = 2;

    localparam logic [REGSEL_WIDTH-1:0] SEL_R0 = 3'd0;
    localparam logic [REGSEL_WIDTH-1:0] SEL_RA = 3'd1;
    localparam logic [REGSEL_WIDTH-1:0] SEL_RB = 3'd2;
    localparam logic [REGSEL_WIDTH-1:0] SEL_RC = 3'd3;
    localparam logic [REGSEL_WIDTH-1:0] SEL_RD = 3'd4;
    localparam logic [REGSEL_WIDTH-1:0] SEL_RE = 3'd5;
    localparam logic [REGSEL_WIDTH-1:0] SEL_SP = 3'd6;
    localparam logic [REGSEL_WIDTH-1:0] SEL_PC = 3'd7;

endpackage

`default_nettype wire

// ==== verilog/nkmm_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module nkmm_fetch #(
    parameter int ADDR_WIDTH = 16
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   stall_i,
    input  wire                   redirect_i,
    input  wire  [ADDR_WIDTH-1:0] redirect_pc_i,
    output logic [ADDR_WIDTH-1:0] pc_o
);

    logic [ADDR_WIDTH-1:0] pc_q;
    logic [ADDR_WIDTH-1:0] pc_next;

    // Jump from writeback wins over a stall
    always_comb begin
        if (redirect_i) begin
            pc_next = redirect_pc_i;
        end else if (stall_i) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + ADDR_WIDTH'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== verilog/nkmm_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module nkmm_decode #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 16
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire  [nkmm_pkg::INSN_WIDTH-1:0]    insn_i,
    input  wire  [ADDR_WIDTH-1:0]              pc_i,
    input  wire                                flush_i,
    input  wire                                ex_valid_i,
    input  wire  [nkmm_pkg::REGSEL_WIDTH-1:0]  ex_d_sel_i,
    input  wire                                res_valid_i,
    input  wire  [nkmm_pkg::REGSEL_WIDTH-1:0]  res_d_sel_i,
    output logic [nkmm_pkg::REGSEL_WIDTH-1:0]  a_sel_o,
    output logic [nkmm_pkg::REGSEL_WIDTH-1:0]  b_sel_o,
    output logic [nkmm_pkg::REGSEL_WIDTH-1:0]  d_sel_rd_o,
    input  wire  [DATA_WIDTH-1:0]              a_val_i,
    input  wire  [DATA_WIDTH-1:0]              b_val_i,
    input  wire  [DATA_WIDTH-1:0]              d_val_i,
    output logic                               stall_o,
    output logic                               valid_o,
    output logic                               mem_write_o,
    output logic                               mem_read_o,
    output logic [nkmm_pkg::OPSEL_WIDTH-1:0]   op_sel_o,
    output logic [DATA_WIDTH-1:0]              alu_a_o,
    output logic [DATA_WIDTH-1:0]              alu_b_o,
    output logic [DATA_WIDTH-1:0]              reg_d_o,
    output logic [nkmm_pkg::REGSEL_WIDTH-1:0]  d_sel_o
);

    logic                                    mem_write;
    logic                                    mem_read;
    logic                                    imm_en;
    logic [nkmm_pkg::OPSEL_WIDTH-1:0]        op_sel;
    logic [nkmm_pkg::IMM_WIDTH-1:0]          imm;
    logic [2:0]                              slot_valid;
    logic [2:0][nkmm_pkg::REGSEL_WIDTH-1:0]  slot_d_sel;
    logic                                    a_busy;
    logic                                    b_busy;
    logic                                    d_busy;

    // Pending write to sel in any later slot but never for R0 or PC
    function automatic logic src_busy(
        input logic [nkmm_pkg::REGSEL_WIDTH-1:0]       sel,
        input logic [2:0]                              valid,
        input logic [2:0][nkmm_pkg::REGSEL_WIDTH-1:0]  dst
    );
        logic hit;
        hit = 1'b0;
        if (sel != nkmm_pkg::SEL_R0 && sel != nkmm_pkg::SEL_PC) begin
            for (int i = 0; i < 3; i++) begin
                hit = hit | (valid[i] && dst[i] == sel);
            end
        end
        return hit;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] operand(
        input logic [nkmm_pkg::REGSEL_WIDTH-1:0] sel,
        input logic [DATA_WIDTH-1:0]             val,
        input logic [ADDR_WIDTH-1:0]             pc
    );
        return (sel == nkmm_pkg::SEL_PC) ? DATA_WIDTH'(pc) : val;
    endfunction

    assign mem_write  = insn_i[nkmm_pkg::MEM_WRITE_BIT];
    assign mem_read   = insn_i[nkmm_pkg::MEM_READ_BIT];
    assign d_sel_rd_o = insn_i[nkmm_pkg::D_SEL_LSB +: nkmm_pkg::REGSEL_WIDTH];
    assign op_sel     = insn_i[nkmm_pkg::OP_SEL_LSB +: nkmm_pkg::OPSEL_WIDTH];
    assign a_sel_o    = insn_i[nkmm_pkg::A_SEL_LSB +: nkmm_pkg::REGSEL_WIDTH];
    assign b_sel_o    = insn_i[nkmm_pkg::B_SEL_LSB +: nkmm_pkg::REGSEL_WIDTH];
    assign imm_en     = insn_i[nkmm_pkg::IMM_EN_BIT];
    assign imm        = insn_i[nkmm_pkg::IMM_WIDTH-1:0];

    // Own slot at index 0 up to the result slot at index 2
    assign slot_valid = {res_valid_i, ex_valid_i, valid_o};
    assign slot_d_sel = {res_d_sel_i, ex_d_sel_i, d_sel_o};

    assign a_busy  = src_busy(a_sel_o, slot_valid, slot_d_sel);
    assign b_busy  = src_busy(b_sel_o, slot_valid, slot_d_sel);
    assign d_busy  = src_busy(d_sel_rd_o, slot_valid, slot_d_sel);
    assign stall_o = a_busy | (b_busy & ~imm_en) | (d_busy & mem_write);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o     <= 1'b0;
            mem_write_o <= 1'b0;
            mem_read_o  <= 1'b0;
        end else begin
            valid_o     <= ~stall_o & ~flush_i;
            mem_write_o <= mem_write;
            mem_read_o  <= mem_read;
        end
    end

    always_ff @(posedge clk) begin
        op_sel_o <= op_sel;
        alu_a_o  <= operand(a_sel_o, a_val_i, pc_i);
        alu_b_o  <= imm_en ? DATA_WIDTH'(imm) : operand(b_sel_o, b_val_i, pc_i);
        reg_d_o  <= operand(d_sel_rd_o, d_val_i, pc_i);
        d_sel_o  <= d_sel_rd_o;
    end

endmodule

`default_nettype wire

// ==== verilog/nkmm_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module nkmm_regfile #(
    parameter int DATA_WIDTH = 32
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire  [nkmm_pkg::REGSEL_WIDTH-1:0]  a_sel_i,
    input  wire  [nkmm_pkg::REGSEL_WIDTH-1:0]  b_sel_i,
    input  wire  [nkmm_pkg::REGSEL_WIDTH-1:0]  d_sel_i,
    output logic [DATA_WIDTH-1:0]              a_val_o,
    output logic [DATA_WIDTH-1:0]              b_val_o,
    output logic [DATA_WIDTH-1:0]              d_val_o,
    input  wire                                wr_en_i,
    input  wire  [nkmm_pkg::REGSEL_WIDTH-1:0]  wr_sel_i,
    input  wire  [DATA_WIDTH-1:0]              wr_data_i
);

    // RA at 1 through SP at 6
    localparam int NUM_REGS = 6;

    logic [NUM_REGS:1][DATA_WIDTH-1:0] regs_q;

    // R0 and the PC code read as zero here
    function automatic logic [DATA_WIDTH-1:0] read_port(
        input logic [nkmm_pkg::REGSEL_WIDTH-1:0]  sel,
        input logic [NUM_REGS:1][DATA_WIDTH-1:0]  regs
    );
        logic [DATA_WIDTH-1:0] val;
        val = '0;
        for (int i = 1; i <= NUM_REGS; i++) begin
            if (int'(sel) == i) begin
                val = regs[i];
            end
        end
        return val;
    endfunction

    assign a_val_o = read_port(a_sel_i, regs_q);
    assign b_val_o = read_port(b_sel_i, regs_q);
    assign d_val_o = read_port(d_sel_i, regs_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            regs_q <= '0;
        end else if (wr_en_i) begin
            for (int i = 1; i <= NUM_REGS; i++) begin
                if (int'(wr_sel_i) == i) begin
                    regs_q[i] <= wr_data_i;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/nkmm_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module nkmm_execute #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 16
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                flush_i,
    input  wire                                valid_i,
    input  wire                                mem_write_i,
    input  wire                                mem_read_i,
    input  wire  [nkmm_pkg::OPSEL_WIDTH-1:0]   op_sel_i,
    input  wire  [DATA_WIDTH-1:0]              alu_a_i,
    input  wire  [DATA_WIDTH-1:0]              alu_b_i,
    input  wire  [DATA_WIDTH-1:0]              reg_d_i,
    input  wire  [nkmm_pkg::REGSEL_WIDTH-1:0]  d_sel_i,
    output logic                               valid_o,
    output logic                               mem_read_o,
    output logic [DATA_WIDTH-1:0]              alu_r_o,
    output logic [nkmm_pkg::REGSEL_WIDTH-1:0]  d_sel_o,
    output logic [ADDR_WIDTH-1:0]              addr_o,
    output logic [DATA_WIDTH-1:0]              data_o,
    output logic                               we_o
);

    logic                  mem_write_q;
    logic [3:0]            shamt;
    logic [DATA_WIDTH-1:0] shifted;
    logic [DATA_WIDTH-1:0] alu_r;

    always_comb begin
        case (alu_b_i[1:0])
            nkmm_pkg::SHI_1: shamt = 4'd1;
            nkmm_pkg::SHI_2: shamt = 4'd2;
            nkmm_pkg::SHI_4: shamt = 4'd4;
            nkmm_pkg::SHI_8: shamt = 4'd8;
        endcase
        shifted = alu_b_i[nkmm_pkg::SHI_LEFT_BIT] ? (alu_a_i << shamt) : (alu_a_i >> shamt);

        case (op_sel_i)
            nkmm_pkg::OP_ADD: alu_r = alu_a_i + alu_b_i;
            nkmm_pkg::OP_SUB: alu_r = alu_a_i - alu_b_i;
            nkmm_pkg::OP_OR:  alu_r = alu_a_i | alu_b_i;
            nkmm_pkg::OP_AND: alu_r = alu_a_i & alu_b_i;
            nkmm_pkg::OP_XOR: alu_r = alu_a_i ^ alu_b_i;
            nkmm_pkg::OP_NOT: alu_r = ~alu_b_i;
            nkmm_pkg::OP_SHI: alu_r = shifted;
            default:          alu_r = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o     <= 1'b0;
            mem_write_q <= 1'b0;
            mem_read_o  <= 1'b0;
        end else begin
            valid_o     <= valid_i & ~flush_i;
            mem_write_q <= mem_write_i;
            mem_read_o  <= mem_read_i;
        end
    end

    always_ff @(posedge clk) begin
        alu_r_o <= alu_r;
        data_o  <= reg_d_i;
        d_sel_o <= d_sel_i;
    end

    assign addr_o = alu_r_o[ADDR_WIDTH-1:0];
    // A store right behind a jump must not reach memory
    assign we_o   = valid_o & mem_write_q & ~flush_i;

endmodule

`default_nettype wire

// ==== verilog/nkmm_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module nkmm_result #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 16
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                valid_i,
    input  wire                                mem_read_i,
    input  wire  [DATA_WIDTH-1:0]              alu_r_i,
    input  wire  [nkmm_pkg::REGSEL_WIDTH-1:0]  d_sel_i,
    input  wire  [DATA_WIDTH-1:0]              data_i,
    output logic                               valid_o,
    output logic [nkmm_pkg::REGSEL_WIDTH-1:0]  d_sel_o,
    output logic                               wr_en_o,
    output logic [nkmm_pkg::REGSEL_WIDTH-1:0]  wr_sel_o,
    output logic [DATA_WIDTH-1:0]              wr_data_o,
    output logic                               redirect_o,
    output logic [ADDR_WIDTH-1:0]              redirect_pc_o,
    output logic                               flush_o
);

    logic                  mem_read_q;
    logic [DATA_WIDTH-1:0] alu_r_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o    <= 1'b0;
            mem_read_q <= 1'b0;
        end else begin
            // The slot behind a jump is dropped too
            valid_o    <= valid_i & ~flush_o;
            mem_read_q <= mem_read_i;
        end
    end

    always_ff @(posedge clk) begin
        alu_r_q <= alu_r_i;
        d_sel_o <= d_sel_i;
    end

    // Registered read data arrives one cycle after the address
    assign wr_data_o = mem_read_q ? data_i : alu_r_q;
    assign wr_sel_o  = d_sel_o;
    assign wr_en_o   = valid_o;

    assign redirect_o    = valid_o && (d_sel_o == nkmm_pkg::SEL_PC);
    assign redirect_pc_o = wr_data_o[ADDR_WIDTH-1:0];
    assign flush_o       = redirect_o;

endmodule

`default_nettype wire

// ==== verilog/nkmm_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module nkmm_cpu #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 16
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [DATA_WIDTH-1:0]            data_i,
    output logic [DATA_WIDTH-1:0]            data_o,
    output logic [ADDR_WIDTH-1:0]            addr_o,
    output logic                             we_o,
    input  wire  [nkmm_pkg::INSN_WIDTH-1:0]  prog_data_i,
    output logic [ADDR_WIDTH-1:0]            prog_addr_o
);

    logic [ADDR_WIDTH-1:0]             pc;
    logic                              stall;
    logic                              redirect;
    logic [ADDR_WIDTH-1:0]             redirect_pc;
    logic                              flush;

    // Register file read side
    logic [nkmm_pkg::REGSEL_WIDTH-1:0] rd_a_sel;
    logic [nkmm_pkg::REGSEL_WIDTH-1:0] rd_b_sel;
    logic [nkmm_pkg::REGSEL_WIDTH-1:0] rd_d_sel;
    logic [DATA_WIDTH-1:0]             rd_a_val;
    logic [DATA_WIDTH-1:0]             rd_b_val;
    logic [DATA_WIDTH-1:0]             rd_d_val;

    // Decode slot
    logic                              dec_valid;
    logic                              dec_mem_write;
    logic                              dec_mem_read;
    logic [nkmm_pkg::OPSEL_WIDTH-1:0]  dec_op_sel;
    logic [DATA_WIDTH-1:0]             dec_alu_a;
    logic [DATA_WIDTH-1:0]             dec_alu_b;
    logic [DATA_WIDTH-1:0]             dec_reg_d;
    logic [nkmm_pkg::REGSEL_WIDTH-1:0] dec_d_sel;

    // Execute slot
    logic                              ex_valid;
    logic                              ex_mem_read;
    logic [DATA_WIDTH-1:0]             ex_alu_r;
    logic [nkmm_pkg::REGSEL_WIDTH-1:0] ex_d_sel;

    // Result slot and writeback
    logic                              res_valid;
    logic [nkmm_pkg::REGSEL_WIDTH-1:0] res_d_sel;
    logic                              wr_en;
    logic [nkmm_pkg::REGSEL_WIDTH-1:0] wr_sel;
    logic [DATA_WIDTH-1:0]             wr_data;

    assign prog_addr_o = pc;

    nkmm_fetch #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) fetch0 (
        .clk(clk), .rst(rst),
        .stall_i(stall), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .pc_o(pc)
    );

    nkmm_decode #(
        .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)
    ) decode0 (
        .clk(clk), .rst(rst),
        .insn_i(prog_data_i), .pc_i(pc), .flush_i(flush),
        .ex_valid_i(ex_valid), .ex_d_sel_i(ex_d_sel),
        .res_valid_i(res_valid), .res_d_sel_i(res_d_sel),
        .a_sel_o(rd_a_sel), .b_sel_o(rd_b_sel), .d_sel_rd_o(rd_d_sel),
        .a_val_i(rd_a_val), .b_val_i(rd_b_val), .d_val_i(rd_d_val),
        .stall_o(stall),
        .valid_o(dec_valid), .mem_write_o(dec_mem_write), .mem_read_o(dec_mem_read),
        .op_sel_o(dec_op_sel), .alu_a_o(dec_alu_a), .alu_b_o(dec_alu_b),
        .reg_d_o(dec_reg_d), .d_sel_o(dec_d_sel)
    );

    nkmm_regfile #(
        .DATA_WIDTH(DATA_WIDTH)
    ) regfile0 (
        .clk(clk), .rst(rst),
        .a_sel_i(rd_a_sel), .b_sel_i(rd_b_sel), .d_sel_i(rd_d_sel),
        .a_val_o(rd_a_val), .b_val_o(rd_b_val), .d_val_o(rd_d_val),
        .wr_en_i(wr_en), .wr_sel_i(wr_sel), .wr_data_i(wr_data)
    );

    nkmm_execute #(
        .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)
    ) execute0 (
        .clk(clk), .rst(rst), .flush_i(flush),
        .valid_i(dec_valid), .mem_write_i(dec_mem_write), .mem_read_i(dec_mem_read),
        .op_sel_i(dec_op_sel), .alu_a_i(dec_alu_a), .alu_b_i(dec_alu_b),
        .reg_d_i(dec_reg_d), .d_sel_i(dec_d_sel),
        .valid_o(ex_valid), .mem_read_o(ex_mem_read), .alu_r_o(ex_alu_r), .d_sel_o(ex_d_sel),
        .addr_o(addr_o), .data_o(data_o), .we_o(we_o)
    );

    nkmm_result #(
        .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)
    ) result0 (
        .clk(clk), .rst(rst),
        .valid_i(ex_valid), .mem_read_i(ex_mem_read), .alu_r_i(ex_alu_r), .d_sel_i(ex_d_sel),
        .data_i(data_i),
        .valid_o(res_valid), .d_sel_o(res_d_sel),
        .wr_en_o(wr_en), .wr_sel_o(wr_sel), .wr_data_o(wr_data),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc), .flush_o(flush)
    );

endmodule

`default_nettype wire

// ==== verif/nkmm_tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module nkmm_tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset covers the first three rising edges
    initial begin
        rst_o = 1'b1;
        repeat (3) @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verif/nkmm_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module nkmm_cpu_tb;

    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 16;
    localparam int TIMEOUT_CYCLES = 3000;
    localparam logic [15:0] END_ADDR = 16'hfff0;

    logic                  clk;
    logic                  rst_gen;
    logic                  rst_test;
    logic                  rst;
    logic [DATA_WIDTH-1:0] data_i;
    logic [DATA_WIDTH-1:0] data_o;
    logic [ADDR_WIDTH-1:0] addr_o;
    logic                  we_o;
    logic [30:0]           prog_data_i;
    logic [ADDR_WIDTH-1:0] prog_addr_o;

    logic [30:0] rom [256];
    logic [31:0] ram [65536];
    logic [31:0] rd_pending;
    logic [15:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [7:0]  emit_addr;
    logic [31:0] lcg_state;
    bit          end_seen;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          errors_before;

    assign rst = rst_gen | rst_test;
    assign prog_data_i = rom[prog_addr_o[7:0]];

    nkmm_tb_clock clock0 (.clk_o(clk), .rst_o(rst_gen));

    nkmm_cpu #(
        .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)
    ) dut0 (
        .clk(clk), .rst(rst),
        .data_i(data_i), .data_o(data_o), .addr_o(addr_o), .we_o(we_o),
        .prog_data_i(prog_data_i), .prog_addr_o(prog_addr_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [15:0] rand16();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[31:16];
    endfunction

    // Power-on contents of the data RAM
    function automatic logic [31:0] fill_word(input logic [15:0] a);
        return {a, a ^ 16'ha5c3};
    endfunction

    function automatic logic [30:0] encode(
        input logic mw, input logic mr, input logic [2:0] d, input logic [2:0] op,
        input logic [2:0] a, input logic [2:0] b, input logic ie, input logic [15:0] imm
    );
        return {mw, mr, d, op, a, b, ie, imm};
    endfunction

    function automatic logic [31:0] model_alu(
        input logic [2:0] op, input logic [31:0] a, input logic [31:0] b
    );
        int amt;
        amt = 1 << b[1:0];
        case (op)
            3'd0: return a + b;
            3'd1: return a - b;
            3'd2: return a | b;
            3'd3: return a & b;
            3'd4: return a ^ b;
            3'd5: return ~b;
            3'd6: return b[2] ? (a << amt) : (a >> amt);
            default: return 32'd0;
        endcase
    endfunction

    task automatic emit(input logic [30:0] insn);
        rom[emit_addr] = insn;
        emit_addr = emit_addr + 8'd1;
    endtask

    task automatic load_imm(input logic [2:0] d, input logic [15:0] v);
        emit(encode(1'b0, 1'b0, d, nkmm_pkg::OP_ADD, nkmm_pkg::SEL_R0, nkmm_pkg::SEL_R0, 1'b1, v));
    endtask

    task automatic store_reg(input logic [2:0] d, input logic [15:0] addr);
        emit(encode(1'b1, 1'b0, d, nkmm_pkg::OP_ADD, nkmm_pkg::SEL_R0, nkmm_pkg::SEL_R0,
                    1'b1, addr));
    endtask

    task automatic load_mem(input logic [2:0] d, input logic [15:0] addr);
        emit(encode(1'b0, 1'b1, d, nkmm_pkg::OP_ADD, nkmm_pkg::SEL_R0, nkmm_pkg::SEL_R0,
                    1'b1, addr));
    endtask

    // Sequential execution of the ROM that records every store in order
    task automatic run_model();
        logic [31:0] regs [8];
        logic [31:0] mm [logic [15:0]];
        logic [15:0] pc;
        logic [30:0] insn;
        logic [2:0]  dsel;
        logic [2:0]  asel;
        logic [2:0]  bsel;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [31:0] r;
        logic [31:0] res;
        bit          done;
        int          steps;
        for (int i = 0; i < 8; i++) begin
            regs[i] = 32'd0;
        end
        pc = 16'd0;
        done = 0;
        steps = 0;
        while (!done && steps < 2000) begin
            insn = rom[pc[7:0]];
            dsel = insn[28:26];
            asel = insn[22:20];
            bsel = insn[19:17];
            a = (asel == 3'd7) ? {16'd0, pc} : regs[asel];
            b = (bsel == 3'd7) ? {16'd0, pc} : regs[bsel];
            d = (dsel == 3'd7) ? {16'd0, pc} : regs[dsel];
            if (insn[16]) begin
                b = {16'd0, insn[15:0]};
            end
            r = model_alu(insn[25:23], a, b);
            res = r;
            if (insn[30]) begin
                exp_addr_q.push_back(r[15:0]);
                exp_data_q.push_back(d);
                mm[r[15:0]] = d;
                done = (r[15:0] == END_ADDR);
            end else if (insn[29]) begin
                res = mm.exists(r[15:0]) ? mm[r[15:0]] : fill_word(r[15:0]);
            end
            if (dsel == 3'd7) begin
                pc = res[15:0];
            end else begin
                pc = pc + 16'd1;
                if (dsel != 3'd0) begin
                    regs[dsel] = res;
                end
            end
            steps++;
        end
    endtask

    // Data RAM with registered read and the store checker
    always @(negedge clk) begin : bus_model
        logic [15:0] ea;
        logic [31:0] ed;
        data_i = rd_pending;
        rd_pending = ram[addr_o];
        if (we_o) begin
            if (exp_addr_q.size() == 0) begin
                $display("Unexpected store of %h to address %h at %0t", data_o, addr_o, $time);
                errors++;
            end else begin
                ea = exp_addr_q.pop_front();
                ed = exp_data_q.pop_front();
                assert (addr_o == ea) else begin
                    $display("Error: %0t addr_o got %h expected %h", $time, addr_o, ea);
                    errors++;
                end
                assert (data_o == ed) else begin
                    $display("Error: %0t data_o got %h expected %h", $time, data_o, ed);
                    errors++;
                end
            end
            if (addr_o == END_ADDR) begin
                end_seen = 1;
            end
            ram[addr_o] = data_o;
        end
    end

    task automatic begin_test();
        @(negedge clk);
        rst_test = 1'b1;
        for (int i = 0; i < 256; i++) begin
            rom[i] = 31'd0;
        end
        for (int i = 0; i < 65536; i++) begin
            ram[i] = fill_word(16'(i));
        end
        rd_pending = 32'd0;
        exp_addr_q.delete();
        exp_data_q.delete();
        end_seen = 0;
        emit_addr = 8'd0;
        errors_before = errors;
    endtask

    task automatic run_test(input string name);
        int cycles;
        store_reg(nkmm_pkg::SEL_R0, END_ADDR);
        run_model();
        repeat (3) @(negedge clk);
        // First fetch after reset comes from address 0
        assert (prog_addr_o == 16'd0) else begin
            $display("Error: %0t prog_addr_o got %h expected %h", $time, prog_addr_o, 16'd0);
            errors++;
        end
        rst_test = 1'b0;
        cycles = 0;
        while (!end_seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!end_seen) begin
            $display("Timeout: test %s never reached its end marker", name);
            errors++;
        end else if (exp_addr_q.size() != 0) begin
            $display("Test %s ended with %0d expected stores missing", name, exp_addr_q.size());
            errors++;
        end
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("Test %s: failed", name);
        end else begin
            $display("Test %s: passed", name);
        end
    endtask

    initial begin : main
        logic [2:0]  cur;
        logic [2:0]  nxt;
        logic [15:0] addr;
        logic [15:0] target;
        int          wait_cycles;
        data_i = 32'd0;
        rst_test = 1'b1;
        rd_pending = 32'd0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = 31'd0;
        end
        lcg_state = 32'h473f_6945;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        wait_cycles = 0;
        while (rst_gen && wait_cycles < 100) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (rst_gen) begin
            $display("Timeout: reset from the clock generator never released");
            errors++;
        end

        begin_test();
        for (int op = 0; op < 8; op++) begin
            load_imm(nkmm_pkg::SEL_RA, rand16());
            load_imm(nkmm_pkg::SEL_RB, rand16());
            emit(encode(1'b0, 1'b0, nkmm_pkg::SEL_RC, 3'(op), nkmm_pkg::SEL_RA,
                        nkmm_pkg::SEL_RB, 1'b0, 16'd0));
            store_reg(nkmm_pkg::SEL_RC, 16'h0100 + 16'(op));
        end
        emit(encode(1'b0, 1'b0, nkmm_pkg::SEL_RD, nkmm_pkg::OP_SUB, nkmm_pkg::SEL_RA,
                    nkmm_pkg::SEL_R0, 1'b1, rand16()));
        store_reg(nkmm_pkg::SEL_RD, 16'h0110);
        run_test("arith");

        begin_test();
        for (int dir = 0; dir < 2; dir++) begin
            for (int amt = 0; amt < 4; amt++) begin
                load_imm(nkmm_pkg::SEL_RA, rand16());
                emit(encode(1'b0, 1'b0, nkmm_pkg::SEL_RB, nkmm_pkg::OP_SHI, nkmm_pkg::SEL_RA,
                            nkmm_pkg::SEL_R0, 1'b1, 16'(dir * 4 + amt)));
                store_reg(nkmm_pkg::SEL_RB, 16'h0180 + 16'(dir * 4 + amt));
            end
        end
        run_test("shifts");

        begin_test();
        load_imm(nkmm_pkg::SEL_RA, rand16());
        cur = nkmm_pkg::SEL_RA;
        for (int k = 0; k < 12; k++) begin
            nxt = 3'((k + 1) % 6 + 1);
            if (k % 2 == 0) begin
                emit(encode(1'b0, 1'b0, nxt, 3'(rand16() % 5), cur, nkmm_pkg::SEL_R0,
                            1'b1, rand16()));
            end else begin
                emit(encode(1'b0, 1'b0, nxt, 3'(rand16() % 5), cur, cur, 1'b0, 16'd0));
            end
            cur = nxt;
            if (k % 4 == 3) begin
                store_reg(cur, 16'h0200 + 16'(k));
            end
        end
        run_test("chain");

        begin_test();
        for (int k = 0; k < 4; k++) begin
            addr = 16'h0300 + (rand16() % 16'd64);
            load_imm(nkmm_pkg::SEL_RA, rand16());
            store_reg(nkmm_pkg::SEL_RA, addr);
            load_mem(nkmm_pkg::SEL_RB, addr);
            store_reg(nkmm_pkg::SEL_RB, addr + 16'h1000);
        end
        load_mem(nkmm_pkg::SEL_RC, 16'h7777);
        store_reg(nkmm_pkg::SEL_RC, 16'h0400);
        run_test("load_store");

        begin_test();
        emit(encode(1'b0, 1'b0, nkmm_pkg::SEL_RA, nkmm_pkg::OP_ADD, nkmm_pkg::SEL_PC,
                    nkmm_pkg::SEL_R0, 1'b0, 16'd0));
        store_reg(nkmm_pkg::SEL_RA, 16'h0500);
        // Direct jump over two stores that must never happen
        target = {8'd0, emit_addr + 8'd3};
        load_imm(nkmm_pkg::SEL_PC, target);
        store_reg(nkmm_pkg::SEL_RB, 16'h05f0);
        store_reg(nkmm_pkg::SEL_RC, 16'h05f1);
        emit(encode(1'b0, 1'b0, nkmm_pkg::SEL_RB, nkmm_pkg::OP_ADD, nkmm_pkg::SEL_PC,
                    nkmm_pkg::SEL_R0, 1'b0, 16'd0));
        store_reg(nkmm_pkg::SEL_RB, 16'h0501);
        // Jump through a register written just before
        target = {8'd0, emit_addr + 8'd3};
        load_imm(nkmm_pkg::SEL_RC, target);
        emit(encode(1'b0, 1'b0, nkmm_pkg::SEL_PC, nkmm_pkg::OP_ADD, nkmm_pkg::SEL_RC,
                    nkmm_pkg::SEL_R0, 1'b1, 16'd0));
        store_reg(nkmm_pkg::SEL_RD, 16'h05f2);
        emit(encode(1'b0, 1'b0, nkmm_pkg::SEL_RD, nkmm_pkg::OP_ADD, nkmm_pkg::SEL_PC,
                    nkmm_pkg::SEL_R0, 1'b1, 16'd5));
        store_reg(nkmm_pkg::SEL_RD, 16'h0502);
        run_test("jumps");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/nkmm_pkg.sv
verilog/nkmm_fetch.sv
verilog/nkmm_decode.sv
verilog/nkmm_regfile.sv
verilog/nkmm_execute.sv
verilog/nkmm_result.sv
verilog/nkmm_cpu.sv
verif/nkmm_tb_clock.sv
verif/nkmm_cpu_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module nkmm_cpu_tb

sim:
	verilator --binary --timing --assert -f project.f --top-module nkmm_cpu_tb \
		-Mdir obj_dir -o nkmm_sim
	./obj_dir/nkmm_sim | tee /dev/stderr | grep -qx 'NO ERRORS'

clean:
	rm -rf obj_dir
